// ==== common/exe_pkg.sv ====
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  excp_cause_t;

    // address error for misaligned access
    localparam excp_cause_t ECODE_ALE = 6'h09;

    localparam word_t INST_BYTES = 32'd4;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JIRL,
        OP_LDW,
        OP_STW
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        alu_op_e     op;
        word_t       src_a;
        word_t       src_b;
        word_t       imm;
        reg_addr_t   rd;
        logic        rd_we;
        // exception already flagged before execute
        logic        excp;
        excp_cause_t excp_cause;
        logic        pred_taken;
        word_t       pred_target;
    } issue_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        alu_op_e     op;
        reg_addr_t   rd;
        logic        rd_we;
        word_t       result;
        logic        mem_rd;
        logic        mem_wr;
        word_t       mem_addr;
        word_t       store_data;
        logic        excp;
        excp_cause_t excp_cause;
        logic        mispredict;
        word_t       redirect_pc;
    } lane_res_t;

    typedef struct packed {
        logic       op;
        word_t      vaddr;
        logic [3:0] wstrb;
        word_t      wdata;
    } dcache_req_t;

endpackage

// ==== exe_lane/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  exe_pkg::alu_op_e op_i,
    input  exe_pkg::word_t   a_i,
    input  exe_pkg::word_t   b_i,
    output exe_pkg::word_t   result_o,
    output logic             lt_o,
    output logic             eq_o
);
    import exe_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       lt_u;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign shamt = b_i[4:0];

    // signed compare drives blt/bge
    assign lt_o = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;
    assign eq_o = (a_i == b_i);

    always_comb begin
        case (op_i)
            OP_SUB:  result_o = diff;
            OP_AND:  result_o = a_i & b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            OP_SLT:  result_o = {31'b0, lt_o};
            OP_SLTU: result_o = {31'b0, lt_u};
            // add also covers address and jirl target
            default: result_o = sum;
        endcase
    end

endmodule

// ==== exe_lane/exe_lane.sv ====
`timescale 1ns/1ps

module exe_lane (
    input  exe_pkg::issue_t    issue_i,
    output exe_pkg::lane_res_t res_o
);
    import exe_pkg::*;

    word_t alu_b;
    word_t alu_res;
    word_t seq_pc;
    word_t target;
    logic  lt;
    logic  eq;
    logic  is_mem;
    logic  is_jirl;
    logic  is_branch;
    logic  taken;
    logic  misaligned;

    assign is_mem    = (issue_i.op == OP_LDW) || (issue_i.op == OP_STW);
    assign is_jirl   = (issue_i.op == OP_JIRL);
    assign is_branch = issue_i.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JIRL};
    assign alu_b     = (is_mem || is_jirl) ? issue_i.imm : issue_i.src_b;

    int_alu u_alu (
        .op_i     (issue_i.op),
        .a_i      (issue_i.src_a),
        .b_i      (alu_b),
        .result_o (alu_res),
        .lt_o     (lt),
        .eq_o     (eq)
    );

    assign seq_pc = issue_i.pc + INST_BYTES;
    assign target = is_jirl ? alu_res : issue_i.pc + issue_i.imm;

    always_comb begin
        case (issue_i.op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // word access only, so both low bits must be clear
    assign misaligned = is_mem && (alu_res[1:0] != 2'b00);

    always_comb begin
        res_o.valid      = issue_i.valid;
        res_o.pc         = issue_i.pc;
        res_o.op         = issue_i.op;
        res_o.rd         = issue_i.rd;
        res_o.rd_we      = issue_i.rd_we;
        res_o.result     = is_jirl ? seq_pc : alu_res;
        res_o.mem_rd     = (issue_i.op == OP_LDW);
        res_o.mem_wr     = (issue_i.op == OP_STW);
        res_o.mem_addr   = alu_res;
        res_o.store_data = issue_i.src_b;
        res_o.excp       = issue_i.excp || misaligned;
        // upstream cause wins over alignment
        res_o.excp_cause = (misaligned && !issue_i.excp) ? ECODE_ALE : issue_i.excp_cause;
        res_o.mispredict = issue_i.valid && is_branch &&
                           ((taken != issue_i.pred_taken) ||
                            (taken && (target != issue_i.pred_target)));
        res_o.redirect_pc = taken ? target : seq_pc;
    end

endmodule

// ==== src/lane_arbiter.sv ====
`timescale 1ns/1ps

module lane_arbiter (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pause_i,
    input  logic                 flush_i,
    input  exe_pkg::lane_res_t   lane0_i,
    input  exe_pkg::lane_res_t   lane1_i,
    output exe_pkg::lane_res_t   keep0_o,
    output exe_pkg::lane_res_t   keep1_o,
    output logic                 dc_req_valid_o,
    output exe_pkg::dcache_req_t dc_req_o,
    output logic                 redirect_o,
    output exe_pkg::word_t       redirect_pc_o,
    output logic                 excp_flush_o
);
    import exe_pkg::*;

    logic        squash1;
    logic        mem_ok0;
    logic        mem_ok1;
    logic        redir0;
    logic        redir1;
    logic        advance;
    lane_res_t   dc_src;
    dcache_req_t dc_req_d;

    // older lane wins, younger one dies behind a mispredict or fault
    assign squash1 = lane0_i.valid && (lane0_i.mispredict || lane0_i.excp);

    always_comb begin
        keep0_o       = lane0_i;
        keep1_o       = lane1_i;
        keep1_o.valid = lane1_i.valid && !squash1;
    end

    assign mem_ok0 = keep0_o.valid && (keep0_o.mem_rd || keep0_o.mem_wr) && !keep0_o.excp;
    assign mem_ok1 = keep1_o.valid && (keep1_o.mem_rd || keep1_o.mem_wr) && !keep1_o.excp;
    assign dc_src  = mem_ok0 ? keep0_o : keep1_o;

    always_comb begin
        dc_req_d.op    = dc_src.mem_wr;
        dc_req_d.vaddr = dc_src.mem_addr;
        dc_req_d.wstrb = dc_src.mem_wr ? 4'hf : 4'h0;
        dc_req_d.wdata = dc_src.store_data;
    end

    assign redir0  = keep0_o.valid && keep0_o.mispredict;
    assign redir1  = keep1_o.valid && keep1_o.mispredict;
    assign advance = !pause_i && !flush_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dc_req_valid_o <= 1'b0;
            redirect_o     <= 1'b0;
            excp_flush_o   <= 1'b0;
        end else begin
            dc_req_valid_o <= advance && (mem_ok0 || mem_ok1);
            redirect_o     <= advance && (redir0 || redir1);
            excp_flush_o   <= advance && ((keep0_o.valid && keep0_o.excp) ||
                                          (keep1_o.valid && keep1_o.excp));
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dc_req_o      <= dc_req_d;
            redirect_pc_o <= redir0 ? keep0_o.redirect_pc : keep1_o.redirect_pc;
        end
    end

    // strobe and fault together only when lane 0 accessed and lane 1 faulted
    a_dc_not_faulting: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_req_valid_o && excp_flush_o |-> $past(mem_ok0 && keep1_o.valid && keep1_o.excp));

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               pause_i,
    input  logic               flush_i,
    input  exe_pkg::lane_res_t keep0_i,
    input  exe_pkg::lane_res_t keep1_i,
    output exe_pkg::lane_res_t mem0_o,
    output exe_pkg::lane_res_t mem1_o
);
    import exe_pkg::*;

    logic      valid0_q;
    logic      valid1_q;
    lane_res_t data0_q;
    lane_res_t data1_q;

    // flush beats pause
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else if (flush_i) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else if (!pause_i) begin
            valid0_q <= keep0_i.valid;
            valid1_q <= keep1_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause_i) begin
            data0_q <= keep0_i;
            data1_q <= keep1_i;
        end
    end

    always_comb begin
        mem0_o       = data0_q;
        mem0_o.valid = valid0_q;
        mem1_o       = data1_q;
        mem1_o.valid = valid1_q;
    end

    a_mem_in_order: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem1_o.valid |-> mem0_o.valid);

endmodule

// ==== src/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pause_i,
    input  logic                 flush_i,
    input  exe_pkg::issue_t      issue0_i,
    input  exe_pkg::issue_t      issue1_i,
    output logic                 dc_req_valid_o,
    output exe_pkg::dcache_req_t dc_req_o,
    output logic                 redirect_o,
    output exe_pkg::word_t       redirect_pc_o,
    output logic                 excp_flush_o,
    output exe_pkg::lane_res_t   mem0_o,
    output exe_pkg::lane_res_t   mem1_o
);
    import exe_pkg::*;

    lane_res_t lane0;
    lane_res_t lane1;
    lane_res_t keep0;
    lane_res_t keep1;

    exe_lane u_lane0 (
        .issue_i (issue0_i),
        .res_o   (lane0)
    );

    exe_lane u_lane1 (
        .issue_i (issue1_i),
        .res_o   (lane1)
    );

    lane_arbiter u_arbiter (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .pause_i        (pause_i),
        .flush_i        (flush_i),
        .lane0_i        (lane0),
        .lane1_i        (lane1),
        .keep0_o        (keep0),
        .keep1_o        (keep1),
        .dc_req_valid_o (dc_req_valid_o),
        .dc_req_o       (dc_req_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .excp_flush_o   (excp_flush_o)
    );

    ex_mem_reg u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pause_i  (pause_i),
        .flush_i  (flush_i),
        .keep0_i  (keep0),
        .keep1_i  (keep1),
        .mem0_o   (mem0_o),
        .mem1_o   (mem1_o)
    );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic arst_n_o
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for eight cycles, released on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_o = 1'b1;
    end
endmodule

// ==== tb/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage;
    import exe_pkg::*;

    localparam int NUM_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    typedef struct packed {
        lane_res_t   m0;
        lane_res_t   m1;
        logic        dc_v;
        dcache_req_t dc;
        logic        redir;
        word_t       rpc;
        logic        xflush;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        pause;
    logic        flush;
    issue_t      issue0;
    issue_t      issue1;
    logic        dc_req_valid;
    dcache_req_t dc_req;
    logic        redirect;
    word_t       redirect_pc;
    logic        excp_flush;
    lane_res_t   mem0;
    lane_res_t   mem1;

    logic [31:0] seed = 32'h2a9d;
    expect_t     exp_q[$];
    expect_t     cur;
    lane_res_t   st0;
    lane_res_t   st1;
    int          cycles;
    int          lane_errs;
    int          dc_errs;
    int          word_errs;

    clk_gen u_clk_gen (
        .clk      (clk),
        .arst_n_o (arst_n)
    );

    exe_stage i_exe_stage (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .pause_i        (pause),
        .flush_i        (flush),
        .issue0_i       (issue0),
        .issue1_i       (issue1),
        .dc_req_valid_o (dc_req_valid),
        .dc_req_o       (dc_req),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .excp_flush_o   (excp_flush),
        .mem0_o         (mem0),
        .mem1_o         (mem1)
    );

    function automatic logic [31:0] next_rand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // expected lane result straight from the ISA rules
    function automatic lane_res_t expect_lane(issue_t iss);
        lane_res_t r;
        word_t     opb;
        word_t     tgt;
        logic      taken;
        logic      is_mem;
        is_mem  = iss.op inside {OP_LDW, OP_STW};
        opb     = (is_mem || iss.op == OP_JIRL) ? iss.imm : iss.src_b;
        r       = '0;
        r.valid = iss.valid;
        r.pc    = iss.pc;
        r.op    = iss.op;
        r.rd    = iss.rd;
        r.rd_we = iss.rd_we;
        case (iss.op)
            OP_SUB:  r.result = iss.src_a - opb;
            OP_AND:  r.result = iss.src_a & opb;
            OP_OR:   r.result = iss.src_a | opb;
            OP_XOR:  r.result = iss.src_a ^ opb;
            OP_SLL:  r.result = iss.src_a << opb[4:0];
            OP_SRL:  r.result = iss.src_a >> opb[4:0];
            OP_SRA:  r.result = $signed(iss.src_a) >>> opb[4:0];
            OP_SLT:  r.result = {31'b0, $signed(iss.src_a) < $signed(opb)};
            OP_SLTU: r.result = {31'b0, iss.src_a < opb};
            OP_JIRL: r.result = iss.pc + INST_BYTES;
            default: r.result = iss.src_a + opb;
        endcase
        case (iss.op)
            OP_BEQ:  taken = (iss.src_a == iss.src_b);
            OP_BNE:  taken = (iss.src_a != iss.src_b);
            OP_BLT:  taken = $signed(iss.src_a) < $signed(iss.src_b);
            OP_BGE:  taken = $signed(iss.src_a) >= $signed(iss.src_b);
            OP_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        tgt          = (iss.op == OP_JIRL) ? iss.src_a + iss.imm : iss.pc + iss.imm;
        r.mem_rd     = (iss.op == OP_LDW);
        r.mem_wr     = (iss.op == OP_STW);
        r.mem_addr   = iss.src_a + iss.imm;
        r.store_data = iss.src_b;
        r.excp       = iss.excp || (is_mem && r.mem_addr[1:0] != 2'b00);
        r.excp_cause = iss.excp ? iss.excp_cause : ECODE_ALE;
        r.mispredict = iss.valid && (iss.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JIRL}) &&
                       (taken != iss.pred_taken || (taken && tgt != iss.pred_target));
        r.redirect_pc = taken ? tgt : iss.pc + INST_BYTES;
        return r;
    endfunction

    function automatic issue_t make_issue(logic valid, logic allow_mem);
        issue_t      iss;
        lane_res_t   r;
        logic [31:0] dice;
        dice            = next_rand();
        iss.valid       = valid;
        iss.pc          = next_rand() & 32'hffff_fffc;
        iss.op          = alu_op_e'(5'(next_rand() % 17));
        iss.src_a       = next_rand();
        iss.src_b       = (dice[1:0] == 2'b00) ? iss.src_a : next_rand();
        iss.imm         = next_rand();
        iss.rd          = 5'(next_rand());
        iss.rd_we       = dice[2];
        iss.excp        = (dice[7:4] == 4'h0);
        iss.excp_cause  = 6'(next_rand());
        iss.pred_taken  = 1'b0;
        iss.pred_target = next_rand();
        if (!allow_mem && (iss.op inside {OP_LDW, OP_STW}))
            iss.op = OP_ADD;
        // most accesses word aligned
        if (dice[9:8] != 2'b00)
            iss.imm = iss.imm - ((iss.src_a + iss.imm) & 32'h3);
        // half the branches predicted right
        r = expect_lane(iss);
        if (dice[10]) begin
            iss.pred_taken  = r.mispredict;
            iss.pred_target = r.redirect_pc;
        end else begin
            // random guess of direction and target
            iss.pred_taken = dice[11];
            if (dice[12])
                iss.pred_target = r.redirect_pc;
        end
        return iss;
    endfunction

    task automatic lane_compare(string what, lane_res_t got, lane_res_t want);
        logic bad;
        bad = (got.valid !== want.valid);
        if (want.valid) begin
            bad |= {got.pc, got.op, got.rd, got.rd_we, got.result} !==
                   {want.pc, want.op, want.rd, want.rd_we, want.result};
            bad |= {got.mem_rd, got.mem_wr, got.excp, got.mispredict, got.redirect_pc} !==
                   {want.mem_rd, want.mem_wr, want.excp, want.mispredict, want.redirect_pc};
            if (want.excp)
                bad |= (got.excp_cause !== want.excp_cause);
            if (want.mem_rd || want.mem_wr)
                bad |= (got.mem_addr !== want.mem_addr);
            if (want.mem_wr)
                bad |= (got.store_data !== want.store_data);
        end
        if (bad) begin
            lane_errs++;
            $display("[ERROR] time %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic dcache_compare(dcache_req_t got, dcache_req_t want);
        logic bad;
        bad = {got.op, got.vaddr, got.wstrb} !== {want.op, want.vaddr, want.wstrb};
        if (want.op)
            bad |= (got.wdata !== want.wdata);
        if (bad) begin
            dc_errs++;
            $display("[ERROR] time %0t: dcache request got %h expected %h", $time, got, want);
        end
    endtask

    task automatic word_compare(string what, word_t got, word_t want);
        if (got !== want) begin
            word_errs++;
            $display("[ERROR] time %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    initial begin
        lane_res_t   k0;
        lane_res_t   k1;
        lane_res_t   src;
        expect_t     e;
        logic        adv;
        logic        ok0;
        logic        ok1;
        logic        r0;
        logic [31:0] dice;
        pause  = 1'b0;
        flush  = 1'b0;
        issue0 = '0;
        issue1 = '0;
        st0    = '0;
        st1    = '0;
        @(posedge arst_n);
        @(negedge clk);
        word_compare("strobes after reset", {29'b0, dc_req_valid, redirect, excp_flush}, '0);
        lane_compare("mem0 after reset", mem0, '0);
        lane_compare("mem1 after reset", mem1, '0);
        for (int n = 0; n < NUM_CYCLES; n++) begin
            dice = next_rand();
            // a paused pair stays on the bus
            if (!pause) begin
                issue0 = make_issue(dice[2:0] != 3'b000, 1'b1);
                issue1 = make_issue(issue0.valid && dice[4:3] != 2'b00,
                                    !(issue0.op inside {OP_LDW, OP_STW}));
            end
            pause = (dice[9:6] == 4'h0);
            flush = (dice[13:10] == 4'h0);
            k0 = expect_lane(issue0);
            k1 = expect_lane(issue1);
            if (k0.valid && (k0.mispredict || k0.excp))
                k1.valid = 1'b0;
            adv      = !pause && !flush;
            ok0      = k0.valid && (k0.mem_rd || k0.mem_wr) && !k0.excp;
            ok1      = k1.valid && (k1.mem_rd || k1.mem_wr) && !k1.excp;
            r0       = k0.valid && k0.mispredict;
            src      = ok0 ? k0 : k1;
            e.dc_v   = adv && (ok0 || ok1);
            e.dc     = {src.mem_wr, src.mem_addr, src.mem_wr ? 4'hf : 4'h0, src.store_data};
            e.redir  = adv && (r0 || (k1.valid && k1.mispredict));
            e.rpc    = r0 ? k0.redirect_pc : k1.redirect_pc;
            e.xflush = adv && ((k0.valid && k0.excp) || (k1.valid && k1.excp));
            if (!pause) begin
                st0 = k0;
                st1 = k1;
            end
            if (flush) begin
                st0.valid = 1'b0;
                st1.valid = 1'b0;
            end
            e.m0 = st0;
            e.m1 = st1;
            exp_q.push_back(e);
            @(negedge clk);
        end
        $display("errors: lane %0d, dcache %0d, word %0d", lane_errs, dc_errs, word_errs);
        if (lane_errs + dc_errs + word_errs == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // sample just after the edge, once outputs settled
    always @(posedge clk) begin
        #1;
        if (exp_q.size() > 0) begin
            cur = exp_q.pop_front();
            lane_compare("mem0", mem0, cur.m0);
            lane_compare("mem1", mem1, cur.m1);
            word_compare("strobes", {29'b0, dc_req_valid, redirect, excp_flush},
                         {29'b0, cur.dc_v, cur.redir, cur.xflush});
            if (cur.dc_v)
                dcache_compare(dc_req, cur.dc);
            if (cur.redir)
                word_compare("redirect_pc", redirect_pc, cur.rpc);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end
endmodule

// ==== exe_stage.f ====
common/exe_pkg.sv
exe_lane/int_alu.sv
exe_lane/exe_lane.sv
src/lane_arbiter.sv
src/ex_mem_reg.sv
src/exe_stage.sv
tb/clk_gen.sv
tb/tb_exe_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FILELIST  ?= exe_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
